// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - files:
      - src/fetch_pkg.sv
      - src/isa_pkg.sv
      - src/imem_port.sv
      - src/predecoder.sv
      - src/pc_sequencer.sv
      - src/fetch_unit.sv
  - target: test
    files:
      - tests/tb_fetch_unit.sv

// ==== sources.f ====
src/fetch_pkg.sv
src/isa_pkg.sv
src/imem_port.sv
src/predecoder.sv
src/pc_sequencer.sv
src/fetch_unit.sv
tests/tb_fetch_unit.sv

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    localparam int xlen = 32;

    // First address fetched after reset.
    localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

    // Read request to instruction memory. req is held until done.
    typedef struct packed {
        logic            req;
        logic [xlen-1:0] addr;
    } mem_req_t;

    // Memory response. data is only meaningful while done is high.
    typedef struct packed {
        logic            done;
        logic [xlen-1:0] data;
    } mem_rsp_t;

    // One fetched instruction, valid for a single cycle.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_out_t;

endpackage

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fetch_pkg::mem_rsp_t        mem_rsp,
    input  logic                       ex_redirect,
    input  logic [fetch_pkg::xlen-1:0] ex_target,
    input  logic                       mul_done,
    input  logic                       div_done,
    output fetch_pkg::mem_req_t        mem_req,
    output fetch_pkg::fetch_out_t      fetch_out
);

    import fetch_pkg::*;
    import isa_pkg::*;

    logic [xlen-1:0] fetch_pc;
    logic            fetch_en;
    logic            rsp_ok;
    logic [xlen-1:0] rsp_data;
    logic [xlen-1:0] req_pc;
    instr_class_e    cls;
    logic [xlen-1:0] jal_target;

    logic            out_valid;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_instr;

    imem_port u_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .fetch_en    (fetch_en),
        .ex_redirect (ex_redirect),
        .mem_rsp     (mem_rsp),
        .mem_req     (mem_req),
        .rsp_ok      (rsp_ok),
        .rsp_data    (rsp_data),
        .req_pc      (req_pc)
    );

    predecoder u_pdec (
        .rsp_data   (rsp_data),
        .req_pc     (req_pc),
        .cls        (cls),
        .jal_target (jal_target)
    );

    pc_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp_ok      (rsp_ok),
        .cls         (cls),
        .jal_target  (jal_target),
        .ex_redirect (ex_redirect),
        .ex_target   (ex_target),
        .mul_done    (mul_done),
        .div_done    (div_done),
        .fetch_pc    (fetch_pc),
        .fetch_en    (fetch_en)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rsp_ok;
        end
    end

    // Word and its address, captured with the accepted response.
    always_ff @(posedge clk) begin
        if (rsp_ok) begin
            out_pc    <= req_pc;
            out_instr <= rsp_data;
        end
    end

    assign fetch_out = '{valid: out_valid, pc: out_pc, instr: out_instr};

endmodule

// ==== src/imem_port.sv ====
`timescale 1ns/1ps

module imem_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fetch_pkg::xlen-1:0] fetch_pc,
    input  logic                       fetch_en,
    input  logic                       ex_redirect,
    input  fetch_pkg::mem_rsp_t        mem_rsp,
    output fetch_pkg::mem_req_t        mem_req,
    output logic                       rsp_ok,
    output logic [fetch_pkg::xlen-1:0] rsp_data,
    output logic [fetch_pkg::xlen-1:0] req_pc
);

    logic busy;
    logic stale;
    logic start;
    logic done;

    assign done = busy & mem_rsp.done;

    // A redirect moves the pc on this edge, so the old pc is not fetched.
    assign start = ~busy & fetch_en & ~ex_redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            stale <= 1'b0;
        end else if (done) begin
            busy  <= 1'b0;                  // Idle for at least one cycle.
            stale <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            stale <= 1'b0;
        end else if (busy && ex_redirect) begin
            stale <= 1'b1;                  // Word in flight is now useless.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_pc <= fetch_pc;
        end
    end

    assign mem_req = '{req: busy, addr: req_pc};

    // Redirect in the done cycle also kills the response.
    assign rsp_ok   = done & ~stale & ~ex_redirect;
    assign rsp_data = mem_rsp.data;

endmodule

// ==== src/isa_pkg.sv ====
package isa_pkg;

    // Major opcodes of RV32I/M.
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_fence  = 7'b0001111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // funct7 that turns opc_op into the M extension.
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Immediate bits in the order they sit in the word.
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // What fetch needs to know about an instruction.
    typedef enum logic [2:0] {
        cls_seq,
        cls_mul,
        cls_div,
        cls_jal,
        cls_jalr
    } instr_class_e;

endpackage

// ==== src/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rsp_ok,
    input  isa_pkg::instr_class_e      cls,
    input  logic [fetch_pkg::xlen-1:0] jal_target,
    input  logic                       ex_redirect,
    input  logic [fetch_pkg::xlen-1:0] ex_target,
    input  logic                       mul_done,
    input  logic                       div_done,
    output logic [fetch_pkg::xlen-1:0] fetch_pc,
    output logic                       fetch_en
);

    import fetch_pkg::*;
    import isa_pkg::*;

    typedef enum logic [1:0] {
        st_run,
        st_wait_mul,
        st_wait_div,
        st_wait_jalr
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic [xlen-1:0] pc_inc;

    assign pc_inc = pc_q + 32'd4;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        if (ex_redirect) begin
            // Execute always wins.
            state_d = st_run;
            pc_d    = ex_target;
        end else begin
            case (state_q)
                st_run: begin
                    if (rsp_ok) begin
                        case (cls)
                            cls_seq:  pc_d = pc_inc;
                            cls_jal:  pc_d = jal_target;
                            cls_mul:  state_d = st_wait_mul;
                            cls_div:  state_d = st_wait_div;
                            cls_jalr: state_d = st_wait_jalr;
                            default:  pc_d = pc_inc;
                        endcase
                    end
                end
                st_wait_mul: begin
                    if (mul_done) begin
                        state_d = st_run;
                        pc_d    = pc_inc;
                    end
                end
                st_wait_div: begin
                    if (div_done) begin
                        state_d = st_run;
                        pc_d    = pc_inc;
                    end
                end
                default: ;                      // jalr only leaves by redirect.
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= st_run;
            pc_q     <= reset_vector;
            fetch_en <= 1'b0;
        end else begin
            state_q  <= state_d;
            pc_q     <= pc_d;
            fetch_en <= (state_d == st_run);   // Rises one cycle after reset.
        end
    end

    assign fetch_pc = pc_q;

endmodule

// ==== src/predecoder.sv ====
`timescale 1ns/1ps

module predecoder (
    input  logic [fetch_pkg::xlen-1:0] rsp_data,
    input  logic [fetch_pkg::xlen-1:0] req_pc,
    output isa_pkg::instr_class_e      cls,
    output logic [fetch_pkg::xlen-1:0] jal_target
);

    import fetch_pkg::*;
    import isa_pkg::*;

    instr_u      word;
    logic [20:0] j_imm;
    logic        is_muldiv;

    assign word = rsp_data;

    // J immediate, bit 0 always zero.
    assign j_imm = {
        word.j_fmt.imm20,
        word.j_fmt.imm19_12,
        word.j_fmt.imm11,
        word.j_fmt.imm10_1,
        1'b0
    };

    assign jal_target = req_pc + {{(xlen - 21){j_imm[20]}}, j_imm};

    assign is_muldiv = (word.r_fmt.opcode == opc_op) &&
                       (word.r_fmt.funct7 == funct7_muldiv);

    always_comb begin
        cls = cls_seq;
        if (is_muldiv) begin
            // funct3 0..3 are the multiplies, 4..7 div and rem.
            if (word.r_fmt.funct3 < 3'd4) begin
                cls = cls_mul;
            end else begin
                cls = cls_div;
            end
        end else begin
            case (word.r_fmt.opcode)
                opc_jal:  cls = cls_jal;
                opc_jalr: cls = cls_jalr;
                default:  cls = cls_seq;   // Branches fall through too.
            endcase
        end
    end

endmodule

// ==== tests/tb_fetch_unit.sv ====
`timescale 1ns/1ps

module tb_fetch_unit;

    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int clk_period = 4;
    localparam int n_fetch    = 400;
    localparam int t_seq      = 0;
    localparam int t_jal      = 1;
    localparam int t_muldiv   = 2;
    localparam int t_jalr     = 3;
    localparam int t_redirect = 4;
    localparam int t_instr    = 5;

    logic         clk = 1'b0;
    logic         rst_n;
    mem_rsp_t     mem_rsp;
    logic         ex_redirect;
    logic [31:0]  ex_target;
    logic         mul_done;
    logic         div_done;
    mem_req_t     mem_req;
    fetch_out_t   fetch_out;

    integer       seed = 32'hdbab;
    instr_class_e cls_tab [256];                // Instruction class per word slot.
    string        names [6] = '{"seq_flow", "jal_target", "muldiv_hold",
                                "jalr_wait", "redirect", "instr_data"};
    int           checks [6];
    int           errors [6];
    int           fetch_count;
    int           total_chk;
    int           total_err;

    logic         mem_pending;
    int           mem_wait;
    logic         ex_pending;
    int           ex_delay;
    instr_class_e ex_kind;
    logic [31:0]  ex_pc;

    logic [31:0]  exp_pc;
    int           exp_test;
    int           hold_test;

    fetch_unit dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_rsp     (mem_rsp),
        .ex_redirect (ex_redirect),
        .ex_target   (ex_target),
        .mul_done    (mul_done),
        .div_done    (div_done),
        .mem_req     (mem_req),
        .fetch_out   (fetch_out)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] jalr_target(input logic [31:0] pc);
        return reset_vector + ((pc ^ (pc >> 9) ^ 32'h40) & 32'h3fc);
    endfunction

    function automatic logic [31:0] addr_hash(input logic [31:0] addr);
        return addr ^ (addr >> 11) ^ (addr >> 23) ^ 32'h5a5a_3c3c;
    endfunction

    // Forward jumps only.
    function automatic logic [31:0] jal_offset(input logic [31:0] addr);
        logic [31:0] h;
        h = addr_hash(addr);
        return 32'(h[5:0]) * 32'd4 + 32'd8;
    endfunction

    // Register fields and immediates are hashed from the full address.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        logic [20:0] off;
        h   = addr_hash(addr);
        off = jal_offset(addr);
        case (cls_tab[addr[9:2]])
            cls_mul:  return {funct7_muldiv, h[14:10], h[19:15], 1'b0, h[1:0], h[11:7], opc_op};
            cls_div:  return {funct7_muldiv, h[14:10], h[19:15], 1'b1, h[1:0], h[11:7], opc_op};
            cls_jal:  return {off[20], off[10:1], off[11], off[19:12], h[11:7], opc_jal};
            cls_jalr: return {h[31:20], h[19:15], 3'b000, h[11:7], opc_jalr};
            default:  return {h[31:20], h[19:15], 3'b000, h[11:7], opc_op_imm};
        endcase
    endfunction

    function automatic logic [31:0] expected_next(input logic [31:0] pc,
                                                  input logic [31:0] word,
                                                  input logic        redirect,
                                                  input logic [31:0] target);
        if (redirect) begin
            return target;
        end
        if (word[6:0] == opc_jal) begin
            return pc + jal_offset(pc);
        end
        if (word[6:0] == opc_jalr) begin
            return jalr_target(pc);              // Where execute will send it.
        end
        return pc + 32'd4;                       // Plain, mul and div.
    endfunction

    task automatic check_value(input int t, input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", names[t], exp, act);
            errors[t]++;
        end
    endtask

    // Memory answers each request once, 1 to 4 cycles after it is seen.
    always @(posedge clk) begin
        if (mem_rsp.done) begin
            mem_rsp     <= '{done: 1'b0, data: '0};
            mem_pending <= 1'b0;
        end else if (mem_req.req) begin
            if (!mem_pending) begin
                mem_pending <= 1'b1;
                mem_wait    <= rand_below(4);
            end else if (mem_wait != 0) begin
                mem_wait <= mem_wait - 1;
            end else begin
                mem_rsp <= '{done: 1'b1, data: mem_word(mem_req.addr)};
            end
        end
    end

    // Execute stage. Random redirects only while nothing is pending.
    always @(posedge clk) begin
        mul_done    <= 1'b0;
        div_done    <= 1'b0;
        ex_redirect <= 1'b0;
        if (rst_n) begin
            if (ex_pending) begin
                if (ex_delay != 0) begin
                    ex_delay <= ex_delay - 1;
                end else begin
                    ex_pending <= 1'b0;
                    case (ex_kind)
                        cls_mul: mul_done <= 1'b1;
                        cls_div: div_done <= 1'b1;
                        default: begin
                            ex_redirect <= 1'b1;
                            ex_target   <= jalr_target(ex_pc);
                        end
                    endcase
                end
            end else if (fetch_out.valid && !ex_redirect &&
                         cls_tab[fetch_out.pc[9:2]] inside {cls_mul, cls_div, cls_jalr}) begin
                ex_pending <= 1'b1;
                ex_kind    <= cls_tab[fetch_out.pc[9:2]];
                ex_pc      <= fetch_out.pc;
                ex_delay   <= rand_below(5);
            end else if (fetch_count > 0 && rand_below(100) < 3) begin
                ex_redirect <= 1'b1;
                ex_target   <= reset_vector + ($random(seed) & 32'h3fc);
            end
        end
    end

    always @(posedge clk) begin : compare
        logic         was_jalr;
        instr_class_e kind;
        if (rst_n) begin
            if (hold_test >= 0) begin
                checks[hold_test]++;
                assert (!mem_req.req) else begin
                    $display("%s: request to %h issued while waiting on execute",
                             names[hold_test], mem_req.addr);
                    errors[hold_test]++;
                end
            end
            was_jalr = (hold_test == t_jalr);
            if (mul_done || div_done || ex_redirect) begin
                hold_test = -1;
            end
            if (fetch_out.valid) begin
                check_value(exp_test, exp_pc, fetch_out.pc);
                check_value(t_instr, mem_word(exp_pc), fetch_out.instr);
                fetch_count++;
                kind = cls_tab[exp_pc[9:2]];
                case (kind)
                    cls_jal:  exp_test = t_jal;
                    cls_mul,
                    cls_div:  exp_test = t_muldiv;
                    cls_jalr: exp_test = t_jalr;
                    default:  exp_test = t_seq;
                endcase
                if (ex_redirect) begin
                    exp_test = t_redirect;
                end else if (kind inside {cls_mul, cls_div, cls_jalr}) begin
                    hold_test = (kind == cls_jalr) ? t_jalr : t_muldiv;
                end
                exp_pc = expected_next(exp_pc, mem_word(exp_pc), ex_redirect, ex_target);
            end else if (ex_redirect) begin
                exp_test = was_jalr ? t_jalr : t_redirect;
                exp_pc   = ex_target;
            end
        end
    end

    initial begin
        #(n_fetch * 30 * clk_period);
        $display("Timeout: %0d of %0d fetches seen before the time limit", fetch_count, n_fetch);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int r;
        for (int i = 0; i < 256; i++) begin
            r = rand_below(16);
            if (r < 9) begin
                cls_tab[i] = cls_seq;
            end else if (r < 11) begin
                cls_tab[i] = cls_mul;
            end else if (r < 13) begin
                cls_tab[i] = cls_div;
            end else if (r < 15) begin
                cls_tab[i] = cls_jal;
            end else begin
                cls_tab[i] = cls_jalr;
            end
        end
        exp_pc      = reset_vector;
        exp_test    = t_seq;
        hold_test   = -1;
        rst_n       <= 1'b0;
        mem_rsp     <= '{done: 1'b0, data: '0};
        ex_redirect <= 1'b0;
        ex_target   <= '0;
        mul_done    <= 1'b0;
        div_done    <= 1'b0;
        mem_pending <= 1'b0;
        mem_wait    <= 0;
        ex_pending  <= 1'b0;
        ex_delay    <= 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait (fetch_count >= n_fetch);
        for (int i = 0; i < 6; i++) begin
            $display("%-12s %0d checks, %0d errors", names[i], checks[i], errors[i]);
            total_chk += checks[i];
            total_err += errors[i];
        end
        $display("Totals: %0d fetches, %0d checks, %0d errors", fetch_count, total_chk, total_err);
        if (total_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
